//--- list.f
+incdir+include
src/cl_scrub_pkg.sv
src/scrub_addr_counter.sv
src/scrub_fsm.sv
src/stat_pipe.sv
src/host_ctl_regs.sv
src/cl_scrub_top.sv
tb/tb_cl_scrub.sv

//--- tb/tb_cl_scrub.sv
// Directed testbench for the scrub block covering reset, stat pipes, FLR, scrubbing and back-pressure
`timescale 1ns/1ns
`include "cl_scrub_config.svh"

module tb_cl_scrub;

   // Burst geometry taken from the region limit and burst length
   localparam int BURST_BYTES = `CL_SCRB_BURST_LEN * 64;
   localparam int NUM_BURSTS = (`CL_SCRB_MAX_ADDR + 1) / BURST_BYTES;
   localparam int WAIT_LIMIT = 1000;
   localparam int STAT_COUNT = 12;

   logic                                      clk;
   logic                                      sync_rst_n;
   logic [31:0]                               ctl0;
   logic [`CL_NUM_DDR-1:0]                    ddr_is_ready;
   logic                                      flr_assert;
   logic                                      flr_done;
   logic [31:0]                               status0;
   logic [31:0]                               id0;
   logic [31:0]                               id1;
   cl_scrub_pkg::scrb_wr_t [`CL_NUM_DDR-1:0]  scrb_wr;
   cl_scrub_pkg::stat_req_t                   stat_req_in;
   cl_scrub_pkg::stat_req_t                   stat_req_out;
   cl_scrub_pkg::stat_ack_t                   stat_ack_in;
   cl_scrub_pkg::stat_ack_t                   stat_ack_out;

   integer  seed;
   int      wr_count [`CL_NUM_DDR];

   cl_scrub_top i_dut
   (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .status0      (status0),
      .id0          (id0),
      .id1          (id1),
      .scrb_wr      (scrb_wr),
      .stat_req_in  (stat_req_in),
      .stat_req_out (stat_req_out),
      .stat_ack_in  (stat_ack_in),
      .stat_ack_out (stat_ack_out)
   );

   always
   begin
      #4 clk = ~clk;
   end

   // --------------------------------------------------------------------------
   // Checking helpers
   // --------------------------------------------------------------------------
   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected)
      begin
         $display("MISMATCH time=%0t signal=%s actual=0x%0h expected=0x%0h",
                  $time, name, actual, expected);
         stop_with_failure("Value check failed");
      end
   endtask

   task automatic clear_write_counts();
      for (int c = 0; c < `CL_NUM_DDR; c++)
      begin
         wr_count[c] = 0;
      end
   endtask

   // Each channel walks its region in burst steps, one call per cycle
   task automatic check_writes(input logic [`CL_NUM_DDR-1:0] allowed);
      for (int c = 0; c < `CL_NUM_DDR; c++)
      begin
         if (scrb_wr[c].wr)
         begin
            if (!allowed[c])
            begin
               stop_with_failure($sformatf("Channel %0d wrote while it had to stay silent", c));
            end
            if (wr_count[c] >= NUM_BURSTS)
            begin
               stop_with_failure($sformatf("Channel %0d wrote past the end of its region", c));
            end
            check_value($sformatf("scrb_wr[%0d].addr", c), scrb_wr[c].addr,
                        64'(wr_count[c]) * BURST_BYTES);
            wr_count[c]++;
         end
      end
   endtask

   // --------------------------------------------------------------------------
   // Tests
   // --------------------------------------------------------------------------
   task automatic test_after_reset();
      int cycles;
      @(negedge clk);
      for (int c = 0; c < `CL_NUM_DDR; c++)
      begin
         check_value($sformatf("scrb_wr[%0d].wr", c), scrb_wr[c].wr, 0);
      end
      check_value("flr_done", flr_done, 0);
      check_value("stat_req_out", stat_req_out, 0);
      check_value("stat_ack_out", stat_ack_out, 0);
      check_value("id0", id0, `CL_ID0);
      check_value("id1", id1, `CL_ID1);
      cycles = 0;
      while (status0[3:0] != 4'hF)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
         begin
            stop_with_failure("Timed out waiting for the ready bits in status0");
         end
      end
      check_value("status0", status0, {`CL_STATUS_TAG, 4'hF, 4'h0, 4'hF});
   endtask

   task automatic test_stat_pipes();
      cl_scrub_pkg::stat_req_t  req_q [$];
      cl_scrub_pkg::stat_ack_t  ack_q [$];
      cl_scrub_pkg::stat_req_t  req_exp;
      cl_scrub_pkg::stat_ack_t  ack_exp;
      logic [63:0]              rnd;
      for (int n = 0; n < STAT_COUNT + `CL_STAT_STAGES; n++)
      begin
         @(posedge clk);
         if (n < STAT_COUNT)
         begin
            rnd[63:32] = $random(seed);
            rnd[31:0] = $random(seed);
            stat_req_in <= rnd[41:0];
            req_q.push_back(rnd[41:0]);
            rnd[63:32] = $random(seed);
            rnd[31:0] = $random(seed);
            stat_ack_in <= rnd[40:0];
            ack_q.push_back(rnd[40:0]);
         end
         else
         begin
            stat_req_in <= '0;
            stat_ack_in <= '0;
         end
         @(negedge clk);
         // The pipes still hold idle values for the first stages
         if (n < `CL_STAT_STAGES)
         begin
            req_exp = '0;
            ack_exp = '0;
         end
         else
         begin
            req_exp = req_q.pop_front();
            ack_exp = ack_q.pop_front();
         end
         check_value("stat_req_out", stat_req_out, req_exp);
         check_value("stat_ack_out", stat_ack_out, ack_exp);
      end
   endtask

   task automatic test_flr();
      @(posedge clk);
      flr_assert <= 1'b1;
      for (int k = 1; k <= 6; k++)
      begin
         @(posedge clk);
         if (k == 1)
         begin
            flr_assert <= 1'b0;
         end
         @(negedge clk);
         check_value("flr_done", flr_done, (k == 2));
      end
   endtask

   task automatic test_single_scrub();
      int cycles;
      clear_write_counts();
      @(posedge clk);
      ctl0 <= 32'h0000_0002;
      cycles = 0;
      // Done bit of channel 1 is status0[5]
      while (!status0[5])
      begin
         @(negedge clk);
         check_writes(4'b0010);
         cycles++;
         if (cycles > WAIT_LIMIT)
         begin
            stop_with_failure("Timed out waiting for channel 1 to finish its scrub");
         end
      end
      check_value("channel 1 write count", wr_count[1], NUM_BURSTS);

      // Debug view of channel 1
      @(posedge clk);
      ctl0 <= 32'h9000_0002;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_value("id0", id0, (NUM_BURSTS - 1) * BURST_BYTES);
      check_value("id1", id1, 0);
      check_value("status0 channel 1 state", status0[20 +: 3], cl_scrub_pkg::DONE);

      @(posedge clk);
      ctl0 <= '0;
      cycles = 0;
      while (status0[31:12] != `CL_STATUS_TAG || status0[7:4] != 4'h0)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
         begin
            stop_with_failure("Timed out waiting for channel 1 to return to idle");
         end
      end
   endtask

   task automatic test_backpressure();
      int cycles;
      int stall;
      clear_write_counts();
      stall = 8 + ({$random(seed)} % 24);
      @(posedge clk);
      ctl0 <= 32'h0000_000F;
      ddr_is_ready <= 4'b1011;
      cycles = 0;
      while (status0[7:4] != 4'hF)
      begin
         @(posedge clk);
         cycles++;
         if (cycles == stall)
         begin
            ddr_is_ready <= 4'hF;
         end
         @(negedge clk);
         check_writes((cycles <= stall) ? 4'b1011 : 4'b1111);
         if (cycles > WAIT_LIMIT)
         begin
            stop_with_failure("Timed out waiting for all channels to finish scrubbing");
         end
      end
      for (int c = 0; c < `CL_NUM_DDR; c++)
      begin
         check_value($sformatf("channel %0d write count", c), wr_count[c], NUM_BURSTS);
      end

      // Drop every enable with the debug view on
      @(posedge clk);
      ctl0 <= 32'h8000_0000;
      cycles = 0;
      // Debug view has a zero nibble above the all-ones field
      while (status0[15:12] != 4'h0 || status0[7:4] != 4'h0)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
         begin
            stop_with_failure("Timed out waiting for the done bits to clear");
         end
      end
      for (int c = 0; c < `CL_NUM_DDR; c++)
      begin
         check_value($sformatf("status0 channel %0d state", c), status0[16 + 4*c +: 3],
                     cl_scrub_pkg::IDLE);
      end
   endtask

   // --------------------------------------------------------------------------
   // Main sequence
   // --------------------------------------------------------------------------
   initial
   begin
      seed = 32'hb4ff_75df;
      clk = 1'b0;
      sync_rst_n = 1'b0;
      ctl0 = '0;
      ddr_is_ready = '1;
      flr_assert = 1'b0;
      stat_req_in = '0;
      stat_ack_in = '0;
      clear_write_counts();
      repeat (16) @(posedge clk);
      sync_rst_n <= 1'b1;

      test_after_reset();
      test_stat_pipes();
      test_flr();
      test_single_scrub();
      test_backpressure();

      $display("Regression passed");
      $finish;
   end

endmodule

//--- src/cl_scrub_top.sv
// Scrub block top: host registers, per-channel scrubbers and retimed statistics path
`timescale 1ns/1ns
`include "cl_scrub_config.svh"

module cl_scrub_top
(
   input  logic                                      clk,
   input  logic                                      sync_rst_n,

   // Host control and status
   input  logic [31:0]                               ctl0,
   input  logic [`CL_NUM_DDR-1:0]                    ddr_is_ready,
   input  logic                                      flr_assert,
   output logic                                      flr_done,
   output logic [31:0]                               status0,
   output logic [31:0]                               id0,
   output logic [31:0]                               id1,

   // Burst writes, one strobe per channel
   output cl_scrub_pkg::scrb_wr_t [`CL_NUM_DDR-1:0]  scrb_wr,

   // Memory statistics
   input  cl_scrub_pkg::stat_req_t                   stat_req_in,
   output cl_scrub_pkg::stat_req_t                   stat_req_out,
   input  cl_scrub_pkg::stat_ack_t                   stat_ack_in,
   output cl_scrub_pkg::stat_ack_t                   stat_ack_out
);

   logic [`CL_NUM_DDR-1:0]                        scrb_en;
   logic [`CL_NUM_DDR-1:0]                        ddr_ready_q;
   logic [`CL_NUM_DDR-1:0]                        ch_clear;
   logic [`CL_NUM_DDR-1:0]                        ch_step;
   logic [`CL_NUM_DDR-1:0]                        ch_last;
   logic [`CL_SCRB_ADDR_W-1:0]                    ch_addr [`CL_NUM_DDR];
   cl_scrub_pkg::scrb_status_t [`CL_NUM_DDR-1:0]  scrb_status;

   // --------------------------------------------------------------------------
   // Host registers
   // --------------------------------------------------------------------------
   host_ctl_regs i_host_ctl_regs
   (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .scrb_status  (scrb_status),
      .scrb_en      (scrb_en),
      .ddr_ready_q  (ddr_ready_q),
      .flr_done     (flr_done),
      .status0      (status0),
      .id0          (id0),
      .id1          (id1)
   );

   // --------------------------------------------------------------------------
   // Scrub channels
   // --------------------------------------------------------------------------
   for (genvar i = 0; i < `CL_NUM_DDR; i++)
   begin : g_ch
      scrub_addr_counter i_addr_counter
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .clear      (ch_clear[i]),
         .step       (ch_step[i]),
         .addr       (ch_addr[i]),
         .last       (ch_last[i])
      );

      scrub_fsm i_scrub_fsm
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (scrb_en[i]),
         .ddr_ready  (ddr_ready_q[i]),
         .addr       (ch_addr[i]),
         .last       (ch_last[i]),
         .clear      (ch_clear[i]),
         .step       (ch_step[i]),
         .wr         (scrb_wr[i]),
         .status     (scrb_status[i])
      );
   end

   // --------------------------------------------------------------------------
   // Statistics retiming, both directions
   // --------------------------------------------------------------------------
   stat_pipe #(.payload_t(cl_scrub_pkg::stat_req_t)) i_stat_req_pipe
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_bus     (stat_req_in),
      .out_bus    (stat_req_out)
   );

   stat_pipe #(.payload_t(cl_scrub_pkg::stat_ack_t)) i_stat_ack_pipe
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_bus     (stat_ack_in),
      .out_bus    (stat_ack_out)
   );

endmodule

//--- src/host_ctl_regs.sv
// Host register path: control capture, status and identity words, FLR done response
`timescale 1ns/1ns
`include "cl_scrub_config.svh"

module host_ctl_regs
(
   input  logic                                          clk,
   input  logic                                          sync_rst_n,

   input  logic [31:0]                                   ctl0,
   input  logic [`CL_NUM_DDR-1:0]                        ddr_is_ready,
   input  logic                                          flr_assert,
   input  cl_scrub_pkg::scrb_status_t [`CL_NUM_DDR-1:0]  scrb_status,

   output logic [`CL_NUM_DDR-1:0]                        scrb_en,
   output logic [`CL_NUM_DDR-1:0]                        ddr_ready_q,

   output logic                                          flr_done,
   output logic [31:0]                                   status0,
   output logic [31:0]                                   id0,
   output logic [31:0]                                   id1
);

   localparam int SEL_W = $clog2(`CL_NUM_DDR);

   cl_scrub_pkg::ctl0_t           ctl0_q;
   logic                          flr_assert_q;
   logic [`CL_NUM_DDR-1:0]        done_bits;
   logic [4*`CL_NUM_DDR-1:0]      dbg_states;
   logic [`CL_SCRB_ADDR_W-1:0]    sel_addr;

   // --------------------------------------------------------------------------
   // Control and ready capture
   // --------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         ctl0_q <= '0;
         ddr_ready_q <= '0;
      end
      else
      begin
         ctl0_q <= ctl0;
         ddr_ready_q <= ddr_is_ready;
      end

   assign scrb_en = ctl0_q.scrb_en;

   // --------------------------------------------------------------------------
   // Status and identity words
   // --------------------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < `CL_NUM_DDR; i++)
      begin
         done_bits[i] = scrb_status[i].done;
         // Channel 0 sits in the lowest nibble
         dbg_states[4*i +: 4] = {1'b0, scrb_status[i].state};
      end
   end

   // Only the low bits of the select pick a channel
   assign sel_addr = scrb_status[ctl0_q.dbg_sel[SEL_W-1:0]].addr;

   always_ff @(posedge clk)
   begin
      if (ctl0_q.dbg_en)
      begin
         status0 <= {dbg_states, 4'b0, 4'hF, done_bits, ddr_ready_q};
         id0 <= sel_addr[31:0];
         id1 <= sel_addr[63:32];
      end
      else
      begin
         status0 <= {`CL_STATUS_TAG, 4'hF, done_bits, ddr_ready_q};
         id0 <= `CL_ID0;
         id1 <= `CL_ID1;
      end
   end

   // --------------------------------------------------------------------------
   // FLR response
   // --------------------------------------------------------------------------
   // Toggles while the request is held, one pulse per short request
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done <= flr_assert_q && !flr_done;
      end

   a_flr_done_pulse : assert property (@(posedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done);

endmodule

//--- src/stat_pipe.sv
// Fixed-depth register pipe that retimes any packed bus
`timescale 1ns/1ns
`include "cl_scrub_config.svh"

module stat_pipe
#(
   parameter type payload_t = logic [7:0]
)
(
   input  logic      clk,
   input  logic      sync_rst_n,

   input  payload_t  in_bus,
   output payload_t  out_bus
);

   // Stage 0 takes the input, the last stage drives the output
   payload_t stage [`CL_STAT_STAGES];

   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         for (int i = 0; i < `CL_STAT_STAGES; i++)
         begin
            stage[i] <= '0;
         end
      end
      else
      begin
         stage[0] <= in_bus;
         for (int i = 1; i < `CL_STAT_STAGES; i++)
         begin
            stage[i] <= stage[i-1];
         end
      end

   assign out_bus = stage[`CL_STAT_STAGES-1];

endmodule

//--- src/scrub_fsm.sv
// Scrub sequencer: walks one channel through its region one burst per ready cycle
`timescale 1ns/1ns
`include "cl_scrub_config.svh"

module scrub_fsm
(
   input  logic                        clk,
   input  logic                        sync_rst_n,

   input  logic                        enable,
   input  logic                        ddr_ready,

   input  logic [`CL_SCRB_ADDR_W-1:0]  addr,
   input  logic                        last,
   output logic                        clear,
   output logic                        step,

   output cl_scrub_pkg::scrb_wr_t      wr,
   output cl_scrub_pkg::scrb_status_t  status
);

   cl_scrub_pkg::scrb_state_e state;
   cl_scrub_pkg::scrb_state_e state_nxt;

   // --------------------------------------------------------------------------
   // Next state and counter control
   // --------------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      clear = 1'b0;
      step = 1'b0;
      case (state)
         cl_scrub_pkg::IDLE:
         begin
            if (enable)
            begin
               // Restart from the bottom of the region
               state_nxt = cl_scrub_pkg::BUSY;
               clear = 1'b1;
            end
         end
         cl_scrub_pkg::BUSY:
         begin
            if (!enable)
            begin
               state_nxt = cl_scrub_pkg::IDLE;
            end
            else if (ddr_ready)
            begin
               step = 1'b1;
               if (last)
               begin
                  state_nxt = cl_scrub_pkg::DONE;
               end
            end
         end
         cl_scrub_pkg::DONE:
         begin
            if (!enable)
            begin
               state_nxt = cl_scrub_pkg::IDLE;
            end
         end
         default:
         begin
            state_nxt = cl_scrub_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         state <= cl_scrub_pkg::IDLE;
      end
      else
      begin
         state <= state_nxt;
      end

   // Write strobe leaves one cycle after the burst is taken
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         wr <= '0;
      end
      else
      begin
         wr.wr <= step;
         if (step)
         begin
            wr.addr <= addr;
         end
      end

   always_comb
   begin
      status.state = state;
      status.done = (state == cl_scrub_pkg::DONE);
      status.addr = addr;
   end

   // A write always comes from a burst taken while busy
   a_wr_only_busy : assert property (@(posedge clk) disable iff (!sync_rst_n)
      wr.wr |-> ($past(state) == cl_scrub_pkg::BUSY));

endmodule

//--- src/scrub_addr_counter.sv
// Burst address counter for one scrub channel, flags the final burst of the region
`timescale 1ns/1ns
`include "cl_scrub_config.svh"

module scrub_addr_counter
(
   input  logic                        clk,
   input  logic                        sync_rst_n,

   input  logic                        clear,
   input  logic                        step,

   output logic [`CL_SCRB_ADDR_W-1:0]  addr,
   output logic                        last
);

   // Bytes per burst
   localparam logic [`CL_SCRB_ADDR_W-1:0] STEP = `CL_SCRB_BURST_LEN * 64;

   // Start of the final whole burst below the region limit
   localparam logic [`CL_SCRB_ADDR_W-1:0] LAST_ADDR =
      ((`CL_SCRB_MAX_ADDR + 1 - STEP) / STEP) * STEP;

   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         addr <= '0;
      end
      else if (clear)
      begin
         addr <= '0;
      end
      else if (step && !last)
      begin
         addr <= addr + STEP;
      end

   // Holds on the final burst so the debug words keep showing it
   assign last = (addr == LAST_ADDR);

   a_addr_in_range : assert property (@(posedge clk) disable iff (!sync_rst_n)
      addr <= `CL_SCRB_MAX_ADDR);

endmodule

//--- src/cl_scrub_pkg.sv
// Scrub block types: control word, per-channel status and write strobes, statistics buses
`include "cl_scrub_config.svh"

package cl_scrub_pkg;

   // Scrubber state, visible in the debug status word
   typedef enum logic [2:0]
   {
      IDLE = 3'd0,
      BUSY = 3'd1,
      DONE = 3'd2
   } scrb_state_e;

   // Host control word
   typedef struct packed
   {
      logic                        dbg_en;
      logic [2:0]                  dbg_sel;
      logic [31-4-`CL_NUM_DDR:0]   rsvd;
      logic [`CL_NUM_DDR-1:0]      scrb_en;
   } ctl0_t;

   typedef struct packed
   {
      scrb_state_e                 state;
      logic                        done;
      logic [`CL_SCRB_ADDR_W-1:0]  addr;
   } scrb_status_t;

   // One burst write toward the memory
   typedef struct packed
   {
      logic                        wr;
      logic [`CL_SCRB_ADDR_W-1:0]  addr;
   } scrb_wr_t;

   // Memory-statistics request and acknowledge
   typedef struct packed
   {
      logic        wr;
      logic        rd;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } stat_req_t;

   typedef struct packed
   {
      logic        ack;
      logic [7:0]  irq;
      logic [31:0] rdata;
   } stat_ack_t;

endpackage

//--- include/cl_scrub_config.svh
// Scrub block configuration: channel count, scrub limits, pipe depth and identity words
`ifndef CL_SCRUB_CONFIG_SVH
`define CL_SCRUB_CONFIG_SVH

// Number of memory channels that get scrubbed
`define CL_NUM_DDR 4

// Last byte address covered by a scrub pass
`define CL_SCRB_MAX_ADDR 64'h1FFF

// Beats per burst, 64 bytes per beat
`define CL_SCRB_BURST_LEN 16
`define CL_SCRB_ADDR_W 64

// Register stages on each memory-statistics direction
`define CL_STAT_STAGES 4

// Identity words and the upper status field outside debug mode
`define CL_ID0 32'hF000_1D0F
`define CL_ID1 32'h1D51_FEDC
`define CL_STATUS_TAG 20'hA1111

`endif
